//--- all.f
+incdir+common
common/exec_pkg.sv
hw/alu/alu.sv
hw/reg_file.sv
hw/operand_select.sv
hw/retire_stage.sv
hw/exec_unit.sv
sim/exec_unit_sva.sv
sim/exec_unit_tb.sv

//--- sim/exec_unit_tb.sv
////////////////////////////////////////////////////////////////////////////
// execute stage testbench
// random operations checked against a register file and ALU model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module exec_unit_tb;

	import exec_pkg::*;

	localparam int NUM_RANDOM     = 200;
	localparam int NUM_CHAIN      = 40;
	localparam int TIMEOUT_CYCLES = 16;

	logic                        clk;
	logic                        rst_n;
	logic                        issue;
	alu_op_e                     op;
	logic [`EXEC_REG_ADDR_W-1:0] src0;
	logic [`EXEC_REG_ADDR_W-1:0] src1;
	logic [`EXEC_REG_ADDR_W-1:0] dst;
	logic [`EXEC_DATA_W-1:0]     imm;
	logic                        imm_sel;
	logic [`EXEC_DATA_W-1:0]     result;
	logic                        result_valid;
	logic                        z;
	logic                        v;
	logic                        c;
	logic                        n;

	logic [`EXEC_DATA_W-1:0] model_regs [`EXEC_REG_COUNT];  // updated at issue
	logic [3:0]              last_flags;                    // {z, v, c, n}
	integer                  seed = 32'h8b243b06;
	int                      err_count;
	int                      test_count;
	int                      test_errs;
	alu_op_e                 op_list [7] = '{alu_sll, alu_add, alu_sub, alu_and,
		alu_or, alu_xor, alu_slt};

	exec_unit u_exec_unit (.*);

	always #2 clk = ~clk;

	task automatic check_result(input logic [`EXEC_DATA_W-1:0] exp,
		input logic [`EXEC_DATA_W-1:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED result expected %h got %h", exp, got);
			err_count++;
		end
	endtask

	task automatic check_flags(input logic [3:0] exp, input logic [3:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED flags zvcn expected %h got %h", exp, got);
			err_count++;
		end
	endtask

	task automatic check_valid(input logic exp, input logic got);
		if (got !== exp) begin
			$display("CHECK FAILED result_valid expected %h got %h", exp, got);
			err_count++;
		end
	endtask

	function automatic logic [`EXEC_DATA_W-1:0] rand_word();
		rand_word = $random(seed);
	endfunction

	function automatic logic [`EXEC_REG_ADDR_W-1:0] rand_reg(input logic nonzero);
		logic [`EXEC_DATA_W-1:0] w;
		w = $random(seed);
		rand_reg = nonzero ? `EXEC_REG_ADDR_W'(1 + (w[15:0] % 31)) : w[`EXEC_REG_ADDR_W-1:0];
	endfunction

	// mostly edge values and shift counts above 31
	function automatic logic [`EXEC_DATA_W-1:0] pick_value();
		logic [`EXEC_DATA_W-1:0] w;
		w = $random(seed);
		case (w[2:0])
			3'd0: pick_value = 32'h0000_0000;
			3'd1: pick_value = 32'h7fff_ffff;
			3'd2: pick_value = 32'h8000_0000;
			3'd3: pick_value = 32'hffff_ffff;
			3'd4: pick_value = 32 + w[13:8];
			3'd5: pick_value = w[12:8];
			default: pick_value = $random(seed);
		endcase
	endfunction

	function automatic logic is_listed(input alu_op_e code);
		is_listed = code inside {alu_sll, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt};
	endfunction

	task automatic model_op(input alu_op_e code, input logic [31:0] a, input logic [31:0] b,
		output logic [31:0] r, output logic [3:0] f);
		logic [32:0] wide;   // sign-extended sum for overflow
		logic [32:0] carry;  // zero-extended sum or difference for carry
		logic        vf;
		logic        cf;
		r  = '0;
		vf = 1'b0;
		cf = 1'b0;
		case (code)
			alu_add: begin
				carry = {1'b0, a} + {1'b0, b};
				wide  = {a[31], a} + {b[31], b};
				r     = carry[31:0];
				cf    = carry[32];
				vf    = wide[32] != wide[31];
			end
			alu_sub: begin
				carry = {1'b0, a} - {1'b0, b};
				wide  = {a[31], a} - {b[31], b};
				r     = carry[31:0];
				cf    = !carry[32];  // no borrow
				vf    = wide[32] != wide[31];
			end
			alu_and: r = a & b;
			alu_or:  r = a | b;
			alu_xor: r = a ^ b;
			alu_slt: r = (a < b) ? 32'd1 : 32'd0;
			alu_sll: r = (b > 31) ? 32'd0 : (a << b[4:0]);
			default: r = '0;
		endcase
		f = is_listed(code) ? {r == 0, vf, cf, r[31]} : 4'b0;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	// issue on a falling edge and check on the next one with issue dropped
	task automatic step_op(input alu_op_e code, input logic [4:0] s0, input logic [4:0] s1,
		input logic [4:0] d, input logic [31:0] im, input logic isel);
		logic [31:0] exp_r;
		logic [3:0]  exp_f;
		int          waited;
		model_op(code, model_regs[s0], isel ? im : model_regs[s1], exp_r, exp_f);
		if (is_listed(code) && (d != 0))
			model_regs[d] = exp_r;
		issue   = 1'b1;
		op      = code;
		src0    = s0;
		src1    = s1;
		dst     = d;
		imm     = im;
		imm_sel = isel;
		@(negedge clk);
		issue  = 1'b0;
		waited = 0;
		while (!result_valid && (waited < TIMEOUT_CYCLES)) begin
			@(negedge clk);
			waited++;
		end
		if (!result_valid) begin
			abort_run("timed out waiting for result_valid");
		end else begin
			if (waited != 0) begin
				$display("result_valid came %0d cycles late", waited);
				err_count++;
			end
			check_result(exp_r, result);
			check_flags(exp_f, {z, v, c, n});
			last_flags = exp_f;
		end
	endtask

	task automatic idle_cycle();
		issue = 1'b0;
		@(negedge clk);
		check_valid(1'b0, result_valid);
		check_flags(last_flags, {z, v, c, n});  // flags hold between issues
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count == test_errs)
			$display("test %0d %s ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
		test_errs = err_count;
	endtask

	initial begin
		logic [4:0] prev;
		logic [4:0] nd;
		logic [6:0] code7;
		clk        = 1'b0;
		rst_n      = 1'b0;
		issue      = 1'b0;
		op         = alu_nop;
		src0       = '0;
		src1       = '0;
		dst        = '0;
		imm        = '0;
		imm_sel    = 1'b0;
		err_count  = 0;
		test_count = 0;
		test_errs  = 0;
		last_flags = 4'b0;
		for (int i = 0; i < `EXEC_REG_COUNT; i++)
			model_regs[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_valid(1'b0, result_valid);  // values held by reset
		check_result('0, result);
		check_flags(4'b0, {z, v, c, n});
		rst_n = 1'b1;
		@(negedge clk);

		check_valid(1'b0, result_valid);
		check_result('0, result);
		check_flags(4'b0, {z, v, c, n});
		for (int r = 0; r < `EXEC_REG_COUNT; r++)
			step_op(alu_or, r[4:0], 5'd0, 5'd0, 32'h0, 1'b1);
		idle_cycle();
		finish_test("reset state");

		for (int r = 1; r < `EXEC_REG_COUNT; r++)
			step_op(alu_add, 5'd0, rand_reg(1'b0), r[4:0], pick_value(), 1'b1);
		idle_cycle();
		for (int r = 1; r < `EXEC_REG_COUNT; r++)
			step_op(alu_or, r[4:0], 5'd0, 5'd0, 32'h0, 1'b1);
		idle_cycle();
		finish_test("register load");

		for (int i = 0; i < NUM_RANDOM; i++) begin
			step_op(op_list[rand_word() % 7], rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0),
				pick_value(), rand_word() & 1);
			if ((rand_word() & 3) == 0)
				idle_cycle();
		end
		idle_cycle();
		finish_test("random ops");

		prev = rand_reg(1'b1);
		for (int i = 0; i < NUM_CHAIN; i++) begin
			nd = rand_reg(1'b1);
			step_op(op_list[rand_word() % 7], prev, i[0] ? prev : rand_reg(1'b0), nd,
				pick_value(), rand_word() & 1);
			prev = nd;
		end
		idle_cycle();
		finish_test("dependent chain");

		for (int i = 0; i < 20; i++) begin
			nd    = rand_reg(1'b1);
			code7 = rand_word();
			if (is_listed(alu_op_e'(code7)) || (code7 == alu_nop))
				code7 = code7 ^ 7'h40;  // lands on an unused code
			if ((i % 4) == 0)
				code7 = alu_nop;
			step_op(alu_add, 5'd0, 5'd0, nd, rand_word(), 1'b1);
			idle_cycle();
			step_op(alu_op_e'(code7), rand_reg(1'b0), rand_reg(1'b0), nd, pick_value(),
				rand_word() & 1);
			step_op(alu_or, nd, 5'd0, 5'd0, 32'h0, 1'b1);
			idle_cycle();
		end
		finish_test("nop and unknown codes");

		for (int i = 0; i < 10; i++) begin
			step_op(alu_add, 5'd0, 5'd0, 5'd0, rand_word(), 1'b1);
			step_op(alu_or, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);  // forwarding cycle
			idle_cycle();
			step_op(alu_or, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
		end
		idle_cycle();
		finish_test("register 0 write");

		$display("tests run %0d, errors %0d", test_count, err_count);
		if (err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/exec_unit_sva.sv
////////////////////////////////////////////////////////////////////////////
// execute stage assertions
// result_valid timing, reset values and flag rules, bound to exec_unit
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module exec_unit_sva (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       issue,
	input exec_pkg::alu_op_e          op,
	input logic [`EXEC_DATA_W-1:0]    result,
	input logic                       result_valid,
	input logic                       z,
	input logic                       v,
	input logic                       c,
	input logic                       n
);

	import exec_pkg::*;

	logic op_listed;  // codes that set flags at all
	logic op_no_vc;   // V and C stay clear

	assign op_listed = op inside {alu_sll, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt};
	assign op_no_vc  = op inside {alu_and, alu_or, alu_xor, alu_slt, alu_sll};

	valid_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
		issue |=> result_valid) else $error("result_valid missing after issue");

	valid_only_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
		!issue |=> !result_valid) else $error("result_valid without issue");

	clear_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !result_valid && ({z, v, c, n} == 4'b0))
		else $error("outputs not clear after reset");

	// nop retires zero with z clear, so only listed codes are checked
	zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && $past(op_listed) |-> z == (result == '0))
		else $error("z does not match result");

	neg_flag: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> n == result[`EXEC_DATA_W-1]) else $error("n does not match result");

	no_vc_flags: assert property (@(posedge clk) disable iff (!rst_n)
		issue && op_no_vc |=> !v && !c) else $error("v or c set by logic, slt or sll");

endmodule

bind exec_unit exec_unit_sva u_exec_unit_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.issue        (issue),
	.op           (op),
	.result       (result),
	.result_valid (result_valid),
	.z            (z),
	.v            (v),
	.c            (c),
	.n            (n)
);

`default_nettype wire

//--- hw/exec_unit.sv
////////////////////////////////////////////////////////////////////////////
// execute stage top
// register file, operand forwarding, ALU and retire register
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module exec_unit (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue,
	input  exec_pkg::alu_op_e            op,
	input  logic [`EXEC_REG_ADDR_W-1:0]  src0,
	input  logic [`EXEC_REG_ADDR_W-1:0]  src1,
	input  logic [`EXEC_REG_ADDR_W-1:0]  dst,
	input  logic [`EXEC_DATA_W-1:0]      imm,
	input  logic                         imm_sel,
	output logic [`EXEC_DATA_W-1:0]      result,
	output logic                         result_valid,
	output logic                         z,
	output logic                         v,
	output logic                         c,
	output logic                         n
);

	logic [`EXEC_DATA_W-1:0]     rd_data0;
	logic [`EXEC_DATA_W-1:0]     rd_data1;
	logic [`EXEC_DATA_W-1:0]     operand0;
	logic [`EXEC_DATA_W-1:0]     operand1;
	logic [`EXEC_DATA_W-1:0]     alu_result;
	logic                        alu_z;
	logic                        alu_v;
	logic                        alu_c;
	logic                        alu_n;
	logic                        wb_en;     // write-back from retire stage
	logic [`EXEC_REG_ADDR_W-1:0] wb_addr;
	logic [`EXEC_DATA_W-1:0]     wb_data;

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr0 (src0),
		.rd_addr1 (src1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.wr_en    (wb_en),
		.wr_addr  (wb_addr),
		.wr_data  (wb_data)
	);

	operand_select u_operand_select (
		.src0     (src0),
		.src1     (src1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.imm      (imm),
		.imm_sel  (imm_sel),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.operand0 (operand0),
		.operand1 (operand1)
	);

	alu u_alu (
		.op       (op),
		.operand0 (operand0),
		.operand1 (operand1),
		.result   (alu_result),
		.z        (alu_z),
		.v        (alu_v),
		.c        (alu_c),
		.n        (alu_n)
	);

	retire_stage u_retire_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.op           (op),
		.dst          (dst),
		.alu_result   (alu_result),
		.alu_z        (alu_z),
		.alu_v        (alu_v),
		.alu_c        (alu_c),
		.alu_n        (alu_n),
		.result       (result),
		.result_valid (result_valid),
		.z            (z),
		.v            (v),
		.c            (c),
		.n            (n),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data)
	);

endmodule

`default_nettype wire

//--- hw/retire_stage.sv
////////////////////////////////////////////////////////////////////////////
// retire stage
// registers result, flags and destination, drives register write-back
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module retire_stage (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue,
	input  exec_pkg::alu_op_e            op,
	input  logic [`EXEC_REG_ADDR_W-1:0]  dst,
	input  logic [`EXEC_DATA_W-1:0]      alu_result,
	input  logic                         alu_z,
	input  logic                         alu_v,
	input  logic                         alu_c,
	input  logic                         alu_n,
	output logic [`EXEC_DATA_W-1:0]      result,
	output logic                         result_valid,
	output logic                         z,
	output logic                         v,
	output logic                         c,
	output logic                         n,
	output logic                         wb_en,
	output logic [`EXEC_REG_ADDR_W-1:0]  wb_addr,
	output logic [`EXEC_DATA_W-1:0]      wb_data
);

	import exec_pkg::*;

	logic                    op_writes;  // listed non-nop codes only
	logic [`EXEC_DATA_W-1:0] result_q;

	assign op_writes = op inside {alu_sll, alu_add, alu_sub, alu_and,
		alu_or, alu_xor, alu_slt};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			wb_en        <= 1'b0;
			result_q     <= '0;
			{z, v, c, n} <= 4'b0;
		end else begin
			result_valid <= issue;  // one pulse per issued op
			wb_en        <= issue && op_writes;
			if (issue) begin
				result_q     <= alu_result;
				{z, v, c, n} <= {alu_z, alu_v, alu_c, alu_n};  // held until next issue
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			wb_addr <= dst;
		end
	end

	// one register feeds both the output and the write-back
	assign result  = result_q;
	assign wb_data = result_q;

endmodule

`default_nettype wire

//--- hw/operand_select.sv
////////////////////////////////////////////////////////////////////////////
// operand select
// forwards the retiring result and muxes the immediate onto operand1
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module operand_select (
	input  logic [`EXEC_REG_ADDR_W-1:0]  src0,
	input  logic [`EXEC_REG_ADDR_W-1:0]  src1,
	input  logic [`EXEC_DATA_W-1:0]      rd_data0,
	input  logic [`EXEC_DATA_W-1:0]      rd_data1,
	input  logic [`EXEC_DATA_W-1:0]      imm,
	input  logic                         imm_sel,   // 1 selects imm for operand1
	input  logic                         wb_en,
	input  logic [`EXEC_REG_ADDR_W-1:0]  wb_addr,
	input  logic [`EXEC_DATA_W-1:0]      wb_data,
	output logic [`EXEC_DATA_W-1:0]      operand0,
	output logic [`EXEC_DATA_W-1:0]      operand1
);

	logic                    fwd0;
	logic                    fwd1;
	logic [`EXEC_DATA_W-1:0] reg_op1;  // operand1 before the imm mux

	// retiring value is not in the file yet, take it from write-back
	assign fwd0 = wb_en && (wb_addr == src0) && (src0 != '0);
	assign fwd1 = wb_en && (wb_addr == src1) && (src1 != '0);

	assign operand0 = fwd0 ? wb_data : rd_data0;
	assign reg_op1  = fwd1 ? wb_data : rd_data1;
	assign operand1 = imm_sel ? imm : reg_op1;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
////////////////////////////////////////////////////////////////////////////
// register file
// two combinational reads, one clocked write, register 0 tied to zero
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module reg_file (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [`EXEC_REG_ADDR_W-1:0]  rd_addr0,
	input  logic [`EXEC_REG_ADDR_W-1:0]  rd_addr1,
	output logic [`EXEC_DATA_W-1:0]      rd_data0,
	output logic [`EXEC_DATA_W-1:0]      rd_data1,
	input  logic                         wr_en,
	input  logic [`EXEC_REG_ADDR_W-1:0]  wr_addr,
	input  logic [`EXEC_DATA_W-1:0]      wr_data
);

	logic [`EXEC_DATA_W-1:0] regs [`EXEC_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;  // writes to r0 dropped
		end
	end

	// r0 always reads zero
	assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
	assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

endmodule

`default_nettype wire

//--- hw/alu/alu.sv
////////////////////////////////////////////////////////////////////////////
// behavioral ALU
// add/sub/and/or/xor/slt/sll on two operands with Z, V, C and N flags
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exec_defines.svh"

module alu (
	input  exec_pkg::alu_op_e         op,        // control code
	input  logic [`EXEC_DATA_W-1:0]   operand0,
	input  logic [`EXEC_DATA_W-1:0]   operand1,
	output logic [`EXEC_DATA_W-1:0]   result,
	output logic                      z,         // zero result
	output logic                      v,         // signed overflow
	output logic                      c,         // carry out / no borrow
	output logic                      n          // negative result
);

	import exec_pkg::*;

	localparam int MSB = `EXEC_DATA_W - 1;

	logic [`EXEC_DATA_W:0]   add_sum;     // carry in the top bit
	logic [`EXEC_DATA_W-1:0] sub_diff;
	logic                    add_ovf;
	logic                    sub_ovf;
	logic                    op_known;    // low for NOP and unlisted codes

	assign add_sum  = {1'b0, operand0} + {1'b0, operand1};
	assign sub_diff = operand0 - operand1;

	// same-sign inputs giving a result of the other sign
	assign add_ovf = (operand0[MSB] == operand1[MSB]) &&
		(add_sum[MSB] != operand0[MSB]);

	// opposite-sign inputs where the result sign differs from operand0
	assign sub_ovf = (operand0[MSB] != operand1[MSB]) &&
		(sub_diff[MSB] != operand0[MSB]);

	always_comb begin
		result   = '0;
		v        = 1'b0;
		c        = 1'b0;
		op_known = 1'b1;

		case (op)
			alu_add: begin
				result = add_sum[MSB:0];
				c      = add_sum[`EXEC_DATA_W];
				v      = add_ovf;
			end

			alu_sub: begin
				result = sub_diff;
				c      = (operand0 >= operand1);  // carry means no borrow
				v      = sub_ovf;
			end

			alu_and: begin
				result = operand0 & operand1;
			end

			alu_or: begin
				result = operand0 | operand1;
			end

			alu_xor: begin
				result = operand0 ^ operand1;
			end

			alu_slt: begin
				// unsigned compare, 1 or 0
				result = (operand0 < operand1) ? `EXEC_DATA_W'(1) : '0;
			end

			alu_sll: begin
				result = operand0 << operand1;  // full amount, >= 32 gives 0
			end

			default: begin
				op_known = 1'b0;  // nop output, flags all clear
			end
		endcase

		z = op_known && (result == '0);
		n = result[MSB];
	end

endmodule

`default_nettype wire

//--- common/exec_pkg.sv
////////////////////////////////////////////////////////////////////////////
// execute stage package
// ALU control code encoding shared by the datapath and the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package exec_pkg;

	// 7-bit control codes, any other value behaves as a NOP
	typedef enum logic [6:0] {
		alu_nop = 7'h00,  // no operation, zero result
		alu_sll = 7'h04,  // shift left logical
		alu_add = 7'h32,
		alu_sub = 7'h34,
		alu_and = 7'h36,
		alu_or  = 7'h37,
		alu_xor = 7'h38,
		alu_slt = 7'h42   // unsigned set less than
	} alu_op_e;

endpackage

`default_nettype wire

//--- common/exec_defines.svh
////////////////////////////////////////////////////////////////////////////
// execute stage sizing macros
// data width, register address width and register count
////////////////////////////////////////////////////////////////////////////

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width
`define EXEC_DATA_W 32

// register file addressing
`define EXEC_REG_ADDR_W 5
`define EXEC_REG_COUNT 32

`endif
